//--- dv/tb_board_top.sv
// Testbench for the board peripheral system, driven through the bus slave port
// Inputs change on falling edges, outputs are sampled on falling edges
// Scan prescaler is shrunk to 4 bits so the display steps every 16 cycles
`default_nettype none

module tb_board_top;

	localparam int ACK_TIMEOUT  = 20;
	localparam int POLL_LIMIT   = 100;
	localparam int SCAN_TIMEOUT = 200;

	logic        clk;
	logic        rst_n;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic [3:0]  wb_sel;
	logic        wb_we;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_ack;
	logic [3:0]  btn;
	logic [7:0]  sw;
	logic [7:0]  led;
	logic [6:0]  seg;
	logic [3:0]  an;
	logic [1:0]  intr;

	// Run bookkeeping
	int          errors;
	int          n_checks;
	int          n_tests;
	int          err_at_start;
	logic [31:0] lcg_state;

	// Reference model of the writable registers
	logic [31:0] m_out;
	logic [31:0] m_oe;
	logic [31:0] m_mask;

	board_top #(
		.SCAN_W (4)
	) board_top_inst (
		.clk_i    (clk),
		.rst_n_i  (rst_n),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat_w),
		.wb_dat_o (wb_dat_r),
		.wb_sel_i (wb_sel),
		.wb_we_i  (wb_we),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_ack_o (wb_ack),
		.btn_i    (btn),
		.sw_i     (sw),
		.led_o    (led),
		.seg_o    (seg),
		.an_o     (an),
		.intr_o   (intr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Helpers
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Page in the top 15 bits, word index in bits 3..2
	function automatic logic [31:0] reg_addr(input logic [14:0] page, input logic [1:0] idx);
		return {page, 13'd0, idx, 2'b00};
	endfunction

	// Byte lanes with sel set take the new value
	function automatic logic [31:0] byte_merge(input logic [31:0] old_v,
		input logic [31:0] new_v, input logic [3:0] sel);
		logic [31:0] lanes;
		lanes = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_v & ~lanes) | (new_v & lanes);
	endfunction

	// Hex font, lit segments high in gfedcba order, then inverted for the pins
	function automatic logic [6:0] seg_font(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("Test %0d %s: %0d errors", n_tests, name, errors - err_at_start);
		err_at_start = errors;
	endtask

	// ------------------------------------------------------------
	// Bus master, one request then wait for ack
	task automatic bus_access(input logic we, input logic [31:0] adr,
		input logic [31:0] wdat, input logic [3:0] sel, output logic [31:0] rdat);
		int waited;
		@(negedge clk);
		wb_adr   = adr;
		wb_dat_w = wdat;
		wb_sel   = sel;
		wb_we    = we;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		waited   = 0;
		rdat     = '0;
		@(negedge clk);
		while (!wb_ack && waited < ACK_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack) begin
			$display("Bus timeout: no ack within %0d cycles for address %h", ACK_TIMEOUT, adr);
			errors++;
		end else begin
			rdat = wb_dat_r;
			// Debug LEDs show cyc, stb, we and ack of this request
			if (!sw[1]) begin
				check_value("led_o bus", 32'(led[3:0]), 32'({2'b11, we, 1'b1}));
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] d, input logic [3:0] s);
		logic [31:0] unused_rd;
		bus_access(1'b1, adr, d, s, unused_rd);
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] d);
		bus_access(1'b0, adr, 32'h0, 4'hf, d);
	endtask

	// Timer control polling until one bit reaches a value
	task automatic poll_ctrl(input int bit_pos, input logic want, output logic [31:0] ctrl);
		int tries;
		tries = 0;
		bus_read(reg_addr(15'h7001, 2'd0), ctrl);
		while (ctrl[bit_pos] !== want && tries < POLL_LIMIT) begin
			bus_read(reg_addr(15'h7001, 2'd0), ctrl);
			tries++;
		end
		if (ctrl[bit_pos] !== want) begin
			$display("Timer control bit %0d never reached %0b within %0d reads",
				bit_pos, want, POLL_LIMIT);
			errors++;
		end
	endtask

	// Count display scan steps seen on the anodes
	task automatic wait_scan_steps(input int n);
		int steps;
		int waited;
		logic [3:0] prev;
		prev   = an;
		steps  = 0;
		waited = 0;
		while (steps < n && waited < SCAN_TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (an !== prev) begin
				steps++;
				prev = an;
			end
		end
		if (steps < n) begin
			$display("Display scan did not advance %0d steps within %0d cycles", n, SCAN_TIMEOUT);
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// Test sequence
	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] rd;
		logic [31:0] exp_in;
		logic [31:0] cmp;
		logic [14:0] page;
		logic [1:0]  idx;
		logic [3:0]  seen;
		int          k;
		int          zeros;

		lcg_state = 32'ha9bc_9cc6;
		errors = 0;
		n_checks = 0;
		n_tests = 0;
		err_at_start = 0;
		m_out = '0;
		m_oe = '0;
		m_mask = '0;
		rst_n = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		btn = '0;
		sw = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// Reset values and unmapped pages
		check_value("intr_o", 32'(intr), 32'h0);
		for (k = 0; k < 4; k++) begin
			bus_read(reg_addr(15'h7002, 2'(k)), rd);
			check_value("gpio reg", rd, 32'h0);
			bus_read(reg_addr(15'h7001, 2'(k)), rd);
			check_value("timer reg", rd, 32'h0);
		end
		for (k = 0; k < 20; k++) begin
			r = next_rand();
			page = r[31:17];
			if (page == 15'h7001 || page == 15'h7002) page = page ^ 15'h0100;
			d = next_rand();
			bus_write({page, r[16:0]}, d, d[3:0]);
			bus_read({page, r[16:0]}, rd);
			check_value("unmapped wb_dat_o", rd, 32'h0);
		end
		end_test("reset and mapping");

		// GPIO out, oe and mask with byte lanes
		sw = 8'h02;
		for (k = 0; k < 30; k++) begin
			r = next_rand();
			d = next_rand();
			idx = (r[1:0] == 2'd0) ? 2'd1 : r[1:0];
			bus_write(reg_addr(15'h7002, idx), d, r[7:4]);
			case (idx)
				2'd1: m_out = byte_merge(m_out, d, r[7:4]);
				2'd2: m_oe = byte_merge(m_oe, d, r[7:4]);
				default: m_mask = byte_merge(m_mask, d, r[7:4]);
			endcase
			bus_read(reg_addr(15'h7002, idx), rd);
			check_value("gpio readback", rd, (idx == 2'd1) ? m_out : (idx == 2'd2) ? m_oe : m_mask);
			check_value("led_o", 32'(led), 32'(m_out[7:0]));
		end
		@(negedge clk);
		sw = 8'h00;
		@(negedge clk);
		// Inputs are zero and the timer is idle, so no interrupt is pending
		check_value("led_o debug top", 32'(led[7:6]), 32'h0);
		check_value("led_o intr", 32'(led[5:4]), 32'h0);
		end_test("gpio registers");

		// Buttons into GPIO inputs and masked interrupt
		for (k = 0; k < 16; k++) begin
			r = next_rand();
			m_mask = next_rand();
			bus_write(reg_addr(15'h7002, 2'd3), m_mask, 4'hf);
			@(negedge clk);
			btn = r[3:0];
			sw = {6'b0, r[4], 1'b0};
			repeat (2) @(negedge clk);
			exp_in = r[4] ? {20'h0, r[3:0], 8'h0} : 32'h0;
			bus_read(reg_addr(15'h7002, 2'd0), rd);
			check_value("gpio in", rd, exp_in);
			check_value("intr_o[1]", 32'(intr[1]), 32'(|(exp_in & m_mask)));
		end
		end_test("buttons and interrupt");
		sw = 8'h00;

		// One-shot compare
		r = next_rand();
		cmp = 32'(r[3:0]) + 32'd4;
		bus_write(reg_addr(15'h7001, 2'd2), 32'h0, 4'hf);
		bus_write(reg_addr(15'h7001, 2'd1), cmp, 4'hf);
		bus_write(reg_addr(15'h7001, 2'd0), 32'h1, 4'hf);
		poll_ctrl(0, 1'b0, rd);
		check_value("timer ctrl", rd, 32'h4);
		check_value("intr_o[0]", 32'(intr[0]), 32'h1);
		check_value("led_o intr", 32'(led[5:4]), 32'h1);
		bus_read(reg_addr(15'h7001, 2'd2), rd);
		check_value("timer cnt", rd, cmp);
		// Write 1 to the flag
		bus_write(reg_addr(15'h7001, 2'd0), 32'h4, 4'hf);
		bus_read(reg_addr(15'h7001, 2'd0), rd);
		check_value("timer ctrl", rd, 32'h0);
		check_value("intr_o[0]", 32'(intr[0]), 32'h0);
		end_test("timer one-shot");

		// Auto-reload keeps running and never passes compare
		r = next_rand();
		cmp = 32'(r[3:0]) + 32'd8;
		bus_write(reg_addr(15'h7001, 2'd2), 32'h0, 4'hf);
		bus_write(reg_addr(15'h7001, 2'd1), cmp, 4'hf);
		bus_write(reg_addr(15'h7001, 2'd0), 32'h3, 4'hf);
		poll_ctrl(2, 1'b1, rd);
		check_value("timer ctrl en and ar", 32'(rd[1:0]), 32'h3);
		for (k = 0; k < 20; k++) begin
			bus_read(reg_addr(15'h7001, 2'd2), rd);
			check_value("timer cnt within compare", 32'(rd <= cmp), 32'h1);
		end
		// Stop first, then clear the flag
		bus_write(reg_addr(15'h7001, 2'd0), 32'h0, 4'hf);
		bus_write(reg_addr(15'h7001, 2'd0), 32'h4, 4'hf);
		bus_read(reg_addr(15'h7001, 2'd0), rd);
		check_value("timer ctrl", rd, 32'h0);
		check_value("intr_o[0]", 32'(intr[0]), 32'h0);
		end_test("timer auto-reload");

		// ------------------------------------------------------------
		// Display scan against the model's out word
		for (k = 0; k < 4; k++) begin
			m_out = next_rand();
			bus_write(reg_addr(15'h7002, 2'd1), m_out, 4'hf);
			wait_scan_steps(4);
			seen = 4'h0;
			for (int c = 0; c < 150; c++) begin
				@(negedge clk);
				zeros = 0;
				for (int a = 0; a < 4; a++) begin
					if (an[a] == 1'b0) begin
						zeros++;
						seen[a] = 1'b1;
						check_value("seg_o", 32'(seg), 32'(seg_font(m_out[4*a +: 4])));
					end
				end
				check_value("an_o low count", 32'(zeros), 32'h1);
			end
			check_value("digits seen", 32'(seen), 32'hf);
		end
		end_test("display");

		$display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/board_top.sv
// Board level peripheral system behind one external bus slave port
// sw_i[1] high gives GPIO the LEDs and buttons, low shows bus debug
// Only sw_i[1] is used, the other switches are spare
// GPIO output enables are not wired to any pin
`default_nettype none

module board_top import soc_pkg::*; #(
	parameter int SCAN_W = SCAN_W_DEF
) (
	input  wire                   clk_i,
	input  wire                   rst_n_i,
	// External bus master port
	input  wire [ADR_W-1:0]       wb_adr_i,
	input  wire [DAT_W-1:0]       wb_dat_i,
	output logic [DAT_W-1:0]      wb_dat_o,
	input  wire [SEL_W-1:0]       wb_sel_i,
	input  wire                   wb_we_i,
	input  wire                   wb_cyc_i,
	input  wire                   wb_stb_i,
	output logic                  wb_ack_o,
	// Board I/O
	input  wire [3:0]             btn_i,
	input  wire [7:0]             sw_i,
	output logic [7:0]            led_o,
	output logic [6:0]            seg_o,
	output logic [NUM_DIGITS-1:0] an_o,
	output logic [1:0]            intr_o
);

	wb_if gpio_bus ();
	wb_if tmr_bus ();

	logic [DAT_W-1:0] gpio_in;
	gpio_out_u        gpio_out;
	logic             gpio_irq;
	logic             tmr_irq;

	// ------------------------------------------------------------
	// Bus fabric and register blocks
	wb_decoder decoder_inst (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_sel_i (wb_sel_i),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.gpio_bus (gpio_bus.master),
		.tmr_bus  (tmr_bus.master)
	);

	gpio_regs gpio_inst (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.bus        (gpio_bus.slave),
		.gpio_in_i  (gpio_in),
		.gpio_out_o (gpio_out),
		.gpio_oe_o  (),
		.irq_o      (gpio_irq)
	);

	timer_regs timer_inst (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.bus     (tmr_bus.slave),
		.irq_o   (tmr_irq)
	);

	sevenseg_scan #(
		.SCAN_W (SCAN_W)
	) sevenseg_inst (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.digits_i (gpio_out),
		.seg_o    (seg_o),
		.an_o     (an_o)
	);

	// ------------------------------------------------------------
	// Buttons on GPIO bits 11..8 only in GPIO mode
	assign gpio_in = {{(DAT_W-12){1'b0}}, (sw_i[1] ? btn_i : 4'b0000), 8'b0};

	// Interrupt vector, timer on bit 0
	assign intr_o = {gpio_irq, tmr_irq};

	// LEDs follow GPIO or show bus activity
	assign led_o = sw_i[1] ? gpio_out.raw[7:0]
		: {2'b00, intr_o, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o};

endmodule

`default_nettype wire

//--- logic/gpio_regs.sv
// GPIO register block with in, out, oe and interrupt mask
// Inputs are sampled once per clock, no debouncing or synchronizer chain
// irq_o is level sensitive on the sampled inputs
`default_nettype none

module gpio_regs import soc_pkg::*; (
	input  wire              clk_i,
	input  wire              rst_n_i,
	wb_if.slave              bus,
	input  wire [DAT_W-1:0]  gpio_in_i,
	output gpio_out_u        gpio_out_o,
	output logic [DAT_W-1:0] gpio_oe_o,
	output logic             irq_o
);

	logic [REG_IDX_W-1:0] idx;
	logic                 req;
	logic                 wr;
	logic                 ack_q;
	logic [DAT_W-1:0]     rd_d;
	logic [DAT_W-1:0]     rd_q;
	logic [DAT_W-1:0]     in_q;
	gpio_out_u            out_q;
	logic [DAT_W-1:0]     oe_q;
	logic [DAT_W-1:0]     mask_q;

	// Taken only while our own ack is low
	assign idx = bus.adr[REG_IDX_HI:REG_IDX_LO];
	assign req = bus.cyc && bus.stb && !ack_q;
	assign wr  = req && bus.we;

	// ------------------------------------------------------------
	// Read mux
	always_comb begin
		case (idx)
			GPIO_REG_IN:   rd_d = in_q;
			GPIO_REG_OUT:  rd_d = out_q.raw;
			GPIO_REG_OE:   rd_d = oe_q;
			GPIO_REG_MASK: rd_d = mask_q;
			default:       rd_d = '0;
		endcase
	end

	// Control and register state
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_q     <= 1'b0;
			in_q      <= '0;
			out_q.raw <= '0;
			oe_q      <= '0;
			mask_q    <= '0;
		end else begin
			ack_q <= req;
			in_q  <= gpio_in_i;
			if (wr) begin
				case (idx)
					GPIO_REG_OUT:  out_q.raw <= wb_merge(out_q.raw, bus.dat_w, bus.sel);
					GPIO_REG_OE:   oe_q <= wb_merge(oe_q, bus.dat_w, bus.sel);
					GPIO_REG_MASK: mask_q <= wb_merge(mask_q, bus.dat_w, bus.sel);
					// In register is read only
					default: ;
				endcase
			end
		end
	end

	// Read data latched at the sampling edge
	always_ff @(posedge clk_i) begin
		if (req) begin
			rd_q <= rd_d;
		end
	end

	// ------------------------------------------------------------
	// Outputs
	assign bus.ack    = ack_q;
	assign bus.dat_r  = rd_q;
	assign gpio_out_o = out_q;
	assign gpio_oe_o  = oe_q;
	assign irq_o      = |(in_q & mask_q);

endmodule

`default_nettype wire

//--- logic/sevenseg_scan.sv
// Four digit multiplexed hex display, anodes and segments active low
// Outputs refresh only at scan steps, so a new digit value
// shows up at the next step of that digit
`default_nettype none

module sevenseg_scan import soc_pkg::*; #(
	parameter int SCAN_W = SCAN_W_DEF
) (
	input  wire                   clk_i,
	input  wire                   rst_n_i,
	input  wire gpio_out_u        digits_i,
	output logic [6:0]            seg_o,
	output logic [NUM_DIGITS-1:0] an_o
);

	logic [SCAN_W-1:0]    pre_q;
	logic [DIG_IDX_W-1:0] idx_q;
	logic [DIG_IDX_W-1:0] idx_nxt;
	logic                 step;

	// Segment pattern g..a, low means lit
	function automatic logic [6:0] hex_font(input logic [3:0] nib);
		case (nib)
			4'h0: hex_font = 7'h40;
			4'h1: hex_font = 7'h79;
			4'h2: hex_font = 7'h24;
			4'h3: hex_font = 7'h30;
			4'h4: hex_font = 7'h19;
			4'h5: hex_font = 7'h12;
			4'h6: hex_font = 7'h02;
			4'h7: hex_font = 7'h78;
			4'h8: hex_font = 7'h00;
			4'h9: hex_font = 7'h10;
			4'ha: hex_font = 7'h08;
			4'hb: hex_font = 7'h03;
			4'hc: hex_font = 7'h46;
			4'hd: hex_font = 7'h21;
			4'he: hex_font = 7'h06;
			default: hex_font = 7'h0e;
		endcase
	endfunction

	// ------------------------------------------------------------
	// Prescaler wrap moves to the next digit
	assign step    = &pre_q;
	assign idx_nxt = idx_q + 1'b1;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pre_q <= '0;
			idx_q <= '0;
			an_o  <= {{(NUM_DIGITS-1){1'b1}}, 1'b0};
			seg_o <= hex_font(4'h0);
		end else begin
			pre_q <= pre_q + 1'b1;
			if (step) begin
				idx_q <= idx_nxt;
				// One anode low, digit 0 on bit 0
				an_o  <= ~(NUM_DIGITS'(1) << idx_nxt);
				seg_o <= hex_font(digits_i.disp.dig[idx_nxt]);
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/soc_pkg.sv
// Shared address map, register layout and types of the peripheral system
// Only pages 7001h and 7002h are mapped. Every other page reads zero
// Registers sit one word apart and take byte writes through sel
`default_nettype none

package soc_pkg;

	// ------------------------------------------------------------
	// Bus geometry
	localparam int ADR_W = 32;
	localparam int DAT_W = 32;
	localparam int SEL_W = DAT_W / 8;

	// Page select bits and the two mapped pages
	localparam int PAGE_HI = 31;
	localparam int PAGE_LO = 17;
	localparam int PAGE_W  = PAGE_HI - PAGE_LO + 1;
	localparam logic [PAGE_W-1:0] PAGE_TIMER = 15'h7001;
	localparam logic [PAGE_W-1:0] PAGE_GPIO  = 15'h7002;

	// Word index inside a page
	localparam int REG_IDX_HI = 3;
	localparam int REG_IDX_LO = 2;
	localparam int REG_IDX_W  = REG_IDX_HI - REG_IDX_LO + 1;

	// ------------------------------------------------------------
	// Register indices
	localparam logic [REG_IDX_W-1:0] GPIO_REG_IN   = 2'd0;
	localparam logic [REG_IDX_W-1:0] GPIO_REG_OUT  = 2'd1;
	localparam logic [REG_IDX_W-1:0] GPIO_REG_OE   = 2'd2;
	localparam logic [REG_IDX_W-1:0] GPIO_REG_MASK = 2'd3;
	localparam logic [REG_IDX_W-1:0] TMR_REG_CTRL  = 2'd0;
	localparam logic [REG_IDX_W-1:0] TMR_REG_CMP   = 2'd1;
	localparam logic [REG_IDX_W-1:0] TMR_REG_CNT   = 2'd2;

	// Timer control bits, flag is write-1-to-clear
	localparam int TMR_EN_BIT  = 0;
	localparam int TMR_AR_BIT  = 1;
	localparam int TMR_IRQ_BIT = 2;

	// Display
	localparam int SCAN_W_DEF = 16;
	localparam int NUM_DIGITS = 4;
	localparam int DIG_IDX_W  = $clog2(NUM_DIGITS);

	// GPIO output word, hex digits in the low half
	typedef struct packed {
		logic [DAT_W-4*NUM_DIGITS-1:0] spare;
		logic [NUM_DIGITS-1:0][3:0]    dig;
	} gpio_disp_t;

	typedef union packed {
		logic [DAT_W-1:0] raw;
		gpio_disp_t       disp;
	} gpio_out_u;

	// Byte lane merge of a bus write into a register
	function automatic logic [DAT_W-1:0] wb_merge(
		input logic [DAT_W-1:0] old_v,
		input logic [DAT_W-1:0] new_v,
		input logic [SEL_W-1:0] sel
	);
		logic [DAT_W-1:0] res;
		res = old_v;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_v[8*b +: 8];
			end
		end
		return res;
	endfunction

endpackage

`default_nettype wire

//--- logic/timer_regs.sv
// One channel compare timer with sticky interrupt flag
// Counter runs at the bus clock, no prescaler
// A compare hit wins over a flag clear in the same cycle
`default_nettype none

module timer_regs import soc_pkg::*; (
	input  wire  clk_i,
	input  wire  rst_n_i,
	wb_if.slave  bus,
	output logic irq_o
);

	logic [REG_IDX_W-1:0] idx;
	logic                 req;
	logic                 wr;
	logic                 ack_q;
	logic                 hit;
	logic                 irq_clr;
	logic                 en_q;
	logic                 ar_q;
	logic                 irq_q;
	logic [DAT_W-1:0]     cnt_q;
	logic [DAT_W-1:0]     cmp_q;
	logic [DAT_W-1:0]     ctrl_w;
	logic [DAT_W-1:0]     ctrl_new;
	logic [DAT_W-1:0]     rd_d;
	logic [DAT_W-1:0]     rd_q;

	assign idx = bus.adr[REG_IDX_HI:REG_IDX_LO];
	assign req = bus.cyc && bus.stb && !ack_q;
	assign wr  = req && bus.we;

	// Counter reached compare while running
	assign hit = en_q && (cnt_q == cmp_q);

	// Write 1 to the flag bit clears it
	assign irq_clr = wr && (idx == TMR_REG_CTRL) && bus.sel[TMR_IRQ_BIT/8]
		&& bus.dat_w[TMR_IRQ_BIT];

	// ------------------------------------------------------------
	// Control word as seen on the bus
	always_comb begin
		ctrl_w = '0;
		ctrl_w[TMR_EN_BIT]  = en_q;
		ctrl_w[TMR_AR_BIT]  = ar_q;
		ctrl_w[TMR_IRQ_BIT] = irq_q;
	end

	assign ctrl_new = wb_merge(ctrl_w, bus.dat_w, bus.sel);

	always_comb begin
		case (idx)
			TMR_REG_CTRL: rd_d = ctrl_w;
			TMR_REG_CMP:  rd_d = cmp_q;
			TMR_REG_CNT:  rd_d = cnt_q;
			default:      rd_d = '0;
		endcase
	end

	// ------------------------------------------------------------
	// Count, compare and bus writes
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			en_q  <= 1'b0;
			ar_q  <= 1'b0;
			irq_q <= 1'b0;
			cnt_q <= '0;
			cmp_q <= '0;
		end else begin
			ack_q <= req;
			irq_q <= hit || (irq_q && !irq_clr);
			if (hit) begin
				// Restart or stop at the compare value
				if (ar_q) begin
					cnt_q <= '0;
				end else begin
					en_q <= 1'b0;
				end
			end else if (en_q) begin
				cnt_q <= cnt_q + 1'b1;
			end
			// Bus writes override the counting above
			if (wr) begin
				case (idx)
					TMR_REG_CTRL: begin
						en_q <= ctrl_new[TMR_EN_BIT];
						ar_q <= ctrl_new[TMR_AR_BIT];
					end
					TMR_REG_CMP: cmp_q <= wb_merge(cmp_q, bus.dat_w, bus.sel);
					TMR_REG_CNT: cnt_q <= wb_merge(cnt_q, bus.dat_w, bus.sel);
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (req) begin
			rd_q <= rd_d;
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rd_q;
	assign irq_o     = irq_q;

endmodule

`default_nettype wire

//--- logic/wb_decoder.sv
// Page decoder for the two register blocks
// Unmapped pages get an ack after one cycle and read as zero
// Address must stay stable until ack, as the bus rule requires
`default_nettype none

module wb_decoder import soc_pkg::*; (
	input  wire              clk_i,
	input  wire              rst_n_i,
	input  wire [ADR_W-1:0]  wb_adr_i,
	input  wire [DAT_W-1:0]  wb_dat_i,
	input  wire [SEL_W-1:0]  wb_sel_i,
	input  wire              wb_we_i,
	input  wire              wb_cyc_i,
	input  wire              wb_stb_i,
	output logic [DAT_W-1:0] wb_dat_o,
	output logic             wb_ack_o,
	wb_if.master             gpio_bus,
	wb_if.master             tmr_bus
);

	logic [PAGE_W-1:0] page;
	logic              hit_gpio;
	logic              hit_tmr;
	logic              unm_ack_q;

	// ------------------------------------------------------------
	// Page match
	assign page     = wb_adr_i[PAGE_HI:PAGE_LO];
	assign hit_gpio = (page == PAGE_GPIO);
	assign hit_tmr  = (page == PAGE_TIMER);

	// Shared request fields go to both slaves
	assign gpio_bus.adr   = wb_adr_i;
	assign gpio_bus.dat_w = wb_dat_i;
	assign gpio_bus.sel   = wb_sel_i;
	assign gpio_bus.we    = wb_we_i;
	assign gpio_bus.cyc   = wb_cyc_i;
	assign tmr_bus.adr    = wb_adr_i;
	assign tmr_bus.dat_w  = wb_dat_i;
	assign tmr_bus.sel    = wb_sel_i;
	assign tmr_bus.we     = wb_we_i;
	assign tmr_bus.cyc    = wb_cyc_i;

	// Strobe only into the matching slave
	assign gpio_bus.stb = wb_stb_i && hit_gpio;
	assign tmr_bus.stb  = wb_stb_i && hit_tmr;

	// Own ack for unmapped pages, same latency as the slaves
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			unm_ack_q <= 1'b0;
		end else begin
			unm_ack_q <= wb_cyc_i && wb_stb_i && !hit_gpio && !hit_tmr && !unm_ack_q;
		end
	end

	// ------------------------------------------------------------
	// Response mux, at most one ack is high at a time
	assign wb_ack_o = gpio_bus.ack || tmr_bus.ack || unm_ack_q;

	always_comb begin
		if (gpio_bus.ack) begin
			wb_dat_o = gpio_bus.dat_r;
		end else if (tmr_bus.ack) begin
			wb_dat_o = tmr_bus.dat_r;
		end else begin
			wb_dat_o = '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/wb_if.sv
// Single slave bus link between the decoder and one register block
// Plain cyc/stb/ack handshake, one request in flight, no stall
`default_nettype none

interface wb_if import soc_pkg::*; ();

	// Request side
	logic [ADR_W-1:0] adr;
	logic [DAT_W-1:0] dat_w;
	logic [SEL_W-1:0] sel;
	logic             we;
	logic             cyc;
	logic             stb;

	// Response side
	logic [DAT_W-1:0] dat_r;
	logic             ack;

	modport master (
		output adr, dat_w, sel, we, cyc, stb,
		input  dat_r, ack
	);

	modport slave (
		input  adr, dat_w, sel, we, cyc, stb,
		output dat_r, ack
	);

endinterface

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the board testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_board_top -Mdir obj_dir

./obj_dir/Vtb_board_top | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failures"

//--- sim.f
logic/soc_pkg.sv
logic/wb_if.sv
logic/wb_decoder.sv
logic/gpio_regs.sv
logic/timer_regs.sv
logic/sevenseg_scan.sv
logic/board_top.sv
dv/tb_board_top.sv
